//--- hw/rv_pkg.sv
package rv_pkg;

	// ------------------------------------------------
	// widths
	// ------------------------------------------------
	localparam int XLEN = 32;
	// pc and data address are word addresses
	localparam int PC_W = 8;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// ------------------------------------------------
	// encodings
	// ------------------------------------------------
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// branch conditions in funct3
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef enum logic [2:0] {
		CLS_ALU_R,
		CLS_ALU_I,
		CLS_BRANCH,
		CLS_LOAD,
		CLS_STORE,
		CLS_JAL,
		CLS_HALT
	} op_class_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// ------------------------------------------------
	// bundles
	// ------------------------------------------------
	typedef struct packed {
		op_class_e cls;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [2:0] funct3;
		alu_op_e alu_op;
		word_t imm;
	} decoded_t;

	// data memory request, strobes are single-cycle
	typedef struct packed {
		logic we;
		logic re;
		pc_t addr;
		word_t wdata;
	} dmem_req_t;

endpackage

//--- hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
	input  word_t inst,
	output decoded_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	// funct7 bit 5, selects sub and sra
	assign alt = inst[30];

	// ------------------------------------------------
	// class, register fields, immediate
	// ------------------------------------------------
	always_comb
	begin
		dec.rd = inst[11:7];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.funct3 = funct3;
		// i-type immediate unless overridden below
		dec.imm = {{20{inst[31]}}, inst[31:20]};
		case (opcode)
			OPC_OP:
				dec.cls = CLS_ALU_R;
			OPC_OP_IMM:
			begin
				dec.cls = CLS_ALU_I;
				// shift amount only, upper bits carry funct7
				if (funct3 == 3'b001 || funct3 == 3'b101)
					dec.imm = {{(XLEN-5){1'b0}}, inst[24:20]};
			end
			OPC_BRANCH:
			begin
				dec.cls = CLS_BRANCH;
				dec.rd = '0;
				// word offset, same field split as store
				dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OPC_LOAD:
				dec.cls = CLS_LOAD;
			OPC_STORE:
			begin
				dec.cls = CLS_STORE;
				dec.rd = '0;
				dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OPC_JAL:
			begin
				dec.cls = CLS_JAL;
				dec.imm = {{12{inst[31]}}, inst[31:12]};
			end
			// zero word or unknown opcode stops the core
			default:
			begin
				dec.cls = CLS_HALT;
				dec.rd = '0;
			end
		endcase
	end

	// alu operation, only meaningful for alu classes
	always_comb
	begin
		dec.alu_op = ALU_ADD;
		if (opcode == OPC_OP || opcode == OPC_OP_IMM)
		begin
			case (funct3)
				3'b000:
				begin
					// no subtract-immediate
					if (opcode == OPC_OP && alt)
						dec.alu_op = ALU_SUB;
					else
						dec.alu_op = ALU_ADD;
				end
				3'b001: dec.alu_op = ALU_SLL;
				3'b010: dec.alu_op = ALU_SLT;
				3'b011: dec.alu_op = ALU_SLTU;
				3'b100: dec.alu_op = ALU_XOR;
				3'b101:
				begin
					if (alt)
						dec.alu_op = ALU_SRA;
					else
						dec.alu_op = ALU_SRL;
				end
				3'b110: dec.alu_op = ALU_OR;
				default: dec.alu_op = ALU_AND;
			endcase
		end
	end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t rs1_data,
	output word_t rs2_data,
	input  logic rf_we,
	input  reg_idx_t rf_waddr,
	input  word_t rf_wdata
);

	word_t regs [NUM_REGS];

	// write port, x0 never written
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (rf_we && rf_waddr != '0)
			regs[rf_waddr] <= rf_wdata;
	end

	// combinational reads, x0 forced to zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input  op_class_e cls,
	input  alu_op_e alu_op,
	input  word_t op_a,
	input  word_t op_b,
	input  word_t imm,
	output word_t alu_result
);

	word_t operand_b;
	logic [4:0] shamt;

	// register form takes rs2, everything else the immediate
	assign operand_b = (cls == CLS_ALU_R) ? op_b : imm;
	assign shamt = operand_b[4:0];

	always_comb
	begin
		if (cls == CLS_LOAD || cls == CLS_STORE)
		begin
			// effective address rs1 + imm
			alu_result = op_a + imm;
		end
		else
		begin
			case (alu_op)
				ALU_ADD: alu_result = op_a + operand_b;
				ALU_SUB: alu_result = op_a - operand_b;
				ALU_AND: alu_result = op_a & operand_b;
				ALU_OR: alu_result = op_a | operand_b;
				ALU_XOR: alu_result = op_a ^ operand_b;
				ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(operand_b)};
				ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < operand_b};
				ALU_SLL: alu_result = op_a << shamt;
				ALU_SRL: alu_result = op_a >> shamt;
				// arithmetic shift keeps the sign bit
				ALU_SRA: alu_result = word_t'($signed(op_a) >>> shamt);
				default: alu_result = op_a + operand_b;
			endcase
		end
	end

endmodule

//--- hw/rv_branch.sv
`timescale 1ns/1ps

module rv_branch import rv_pkg::*; (
	input  op_class_e cls,
	input  logic [2:0] funct3,
	input  word_t op_a,
	input  word_t op_b,
	input  word_t imm,
	input  pc_t pc,
	output logic take_branch,
	output pc_t branch_target
);

	logic cond;

	// branch condition from funct3
	always_comb
	begin
		case (funct3)
			F3_BEQ: cond = (op_a == op_b);
			F3_BNE: cond = (op_a != op_b);
			F3_BLT: cond = ($signed(op_a) < $signed(op_b));
			F3_BGE: cond = ($signed(op_a) >= $signed(op_b));
			F3_BLTU: cond = (op_a < op_b);
			F3_BGEU: cond = (op_a >= op_b);
			default: cond = 1'b0;
		endcase
	end

	// jal always taken
	assign take_branch = (cls == CLS_JAL) || (cls == CLS_BRANCH && cond);
	// offset in words, wraps in the 8-bit space
	assign branch_target = pc + imm[PC_W-1:0];

endmodule

//--- hw/rv_control.sv
`timescale 1ns/1ps

module rv_control import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic imem_en,
	output pc_t imem_addr,
	input  word_t imem_data,
	input  decoded_t dec,
	output word_t inst,
	input  word_t rs1_data,
	input  word_t rs2_data,
	output word_t op_a,
	output word_t op_b,
	input  word_t alu_result,
	input  logic take_branch,
	input  pc_t branch_target,
	output dmem_req_t dmem_req,
	input  word_t dmem_rdata,
	output logic rf_we,
	output reg_idx_t rf_waddr,
	output word_t rf_wdata,
	output logic done
);

	// eight states per instruction, every class
	typedef enum logic [3:0] {
		IDLE,
		FETCH,
		FETCH_WAIT,
		DECODE,
		READ,
		EXEC,
		MEM,
		MEM_WAIT,
		WRITEBACK,
		HALT
	} state_e;

	state_e state, state_nxt;
	pc_t pc;
	pc_t pc_inc;
	pc_t next_pc;
	word_t rd_val;
	logic has_rd;

	assign pc_inc = pc + pc_t'(1);
	// classes that write rd
	assign has_rd = (dec.cls == CLS_ALU_R) || (dec.cls == CLS_ALU_I) ||
		(dec.cls == CLS_LOAD) || (dec.cls == CLS_JAL);

	// ------------------------------------------------
	// state sequencing
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (start)
					state_nxt = FETCH;
			end
			FETCH: state_nxt = FETCH_WAIT;
			FETCH_WAIT: state_nxt = DECODE;
			DECODE:
			begin
				if (dec.cls == CLS_HALT)
					state_nxt = HALT;
				else
					state_nxt = READ;
			end
			READ: state_nxt = EXEC;
			EXEC: state_nxt = MEM;
			MEM: state_nxt = MEM_WAIT;
			MEM_WAIT: state_nxt = WRITEBACK;
			WRITEBACK: state_nxt = FETCH;
			// held until reset
			HALT: state_nxt = HALT;
			default: state_nxt = IDLE;
		endcase
	end

	// pc only moves at writeback
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			pc <= '0;
		else if (state == WRITEBACK)
			pc <= next_pc;
	end

	// ------------------------------------------------
	// datapath registers
	// ------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			// memory data valid one cycle after the fetch strobe
			FETCH_WAIT: inst <= imem_data;
			READ:
			begin
				op_a <= rs1_data;
				op_b <= rs2_data;
			end
			EXEC:
			begin
				// link value for jal, alu result otherwise
				if (dec.cls == CLS_JAL)
					rd_val <= {{(XLEN-PC_W){1'b0}}, pc_inc};
				else
					rd_val <= alu_result;
				if (take_branch)
					next_pc <= branch_target;
				else
					next_pc <= pc_inc;
			end
			MEM_WAIT:
			begin
				if (dec.cls == CLS_LOAD)
					rd_val <= dmem_rdata;
			end
			default:
			begin
			end
		endcase
	end

	// ------------------------------------------------
	// strobes and ports
	// ------------------------------------------------
	assign imem_en = (state == FETCH);
	assign imem_addr = pc;

	always_comb
	begin
		dmem_req.we = (state == MEM) && (dec.cls == CLS_STORE);
		dmem_req.re = (state == MEM) && (dec.cls == CLS_LOAD);
		// address stays valid, operands held since read
		dmem_req.addr = alu_result[PC_W-1:0];
		dmem_req.wdata = op_b;
	end

	assign rf_we = (state == WRITEBACK) && has_rd;
	assign rf_waddr = dec.rd;
	assign rf_wdata = rd_val;
	assign done = (state == HALT);

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic imem_en,
	output pc_t imem_addr,
	input  word_t imem_data,
	output dmem_req_t dmem_req,
	input  word_t dmem_rdata,
	output logic done
);

	decoded_t dec;
	word_t inst;
	word_t rs1_data;
	word_t rs2_data;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic take_branch;
	pc_t branch_target;
	logic rf_we;
	reg_idx_t rf_waddr;
	word_t rf_wdata;

	// ------------------------------------------------
	// sequencing and writeback
	// ------------------------------------------------
	rv_control u_control (
		.clk(clk),
		.rst(rst),
		.start(start),
		.imem_en(imem_en),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dec(dec),
		.inst(inst),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.op_a(op_a),
		.op_b(op_b),
		.alu_result(alu_result),
		.take_branch(take_branch),
		.branch_target(branch_target),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.done(done)
	);

	rv_decoder u_decoder (
		.inst(inst),
		.dec(dec)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.rs1(dec.rs1),
		.rs2(dec.rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata)
	);

	// ------------------------------------------------
	// execute, alu and branch side by side
	// ------------------------------------------------
	rv_alu u_alu (
		.cls(dec.cls),
		.alu_op(dec.alu_op),
		.op_a(op_a),
		.op_b(op_b),
		.imm(dec.imm),
		.alu_result(alu_result)
	);

	// fetch address is the current pc
	rv_branch u_branch (
		.cls(dec.cls),
		.funct3(dec.funct3),
		.op_a(op_a),
		.op_b(op_b),
		.imm(dec.imm),
		.pc(imem_addr),
		.take_branch(take_branch),
		.branch_target(branch_target)
	);

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

	// body, 31 epilogue stores, halt word
	localparam int BODY_LEN = 40;
	localparam int PROG_LEN = BODY_LEN + NUM_REGS;
	localparam int EPI_BASE = 128;
	// 8 cycles per instruction plus margin for reset and start
	localparam int MAX_CYCLES = 8 * PROG_LEN + 100;
	localparam logic [2:0] BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

	logic clk = 1'b0;
	logic rst = 1'b0;
	logic start = 1'b0;
	word_t imem_data = '0;
	word_t dmem_rdata = '0;
	logic imem_en;
	pc_t imem_addr;
	dmem_req_t dmem_req;
	logic done;

	// program as generated, before encoding
	op_class_e p_kind [256];
	// alu op 0..9 add sub and or xor slt sltu sll srl sra, funct3 for branches
	int p_op [256];
	int p_rd [256];
	int p_rs1 [256];
	int p_rs2 [256];
	word_t p_imm [256];

	word_t imem [256];
	word_t dmem [256];
	// reference copies
	word_t mmem [256];
	word_t mregs [NUM_REGS];
	pc_t fetch_trace [$];
	pc_t store_addr_log [$];
	word_t store_data_log [$];

	logic [31:0] rng_state = 32'hf9f7_d03c;
	int error_count = 0;
	int fetch_idx = 0;
	int store_idx = 0;
	int cycle_count = 0;

	rv_core dut0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.imem_en(imem_en),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.done(done)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function word_t next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper half only, low lcg bits are weak
	function int rand_below(input int n);
		word_t r;
		r = next_rand();
		return int'(r[31:16]) % n;
	endfunction

	task compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			error_count++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function word_t alu_ref(input int op, input word_t a, input word_t b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			6: return (a < b) ? 32'd1 : 32'd0;
			7: return a << b[4:0];
			8: return a >> b[4:0];
			9: return word_t'($signed(a) >>> b[4:0]);
			default: return '0;
		endcase
	endfunction

	function logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			F3_BEQ: return a == b;
			F3_BNE: return a != b;
			F3_BLT: return $signed(a) < $signed(b);
			F3_BGE: return $signed(a) >= $signed(b);
			F3_BLTU: return a < b;
			F3_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// rv32i field layout, branch offset in the store split, jal raw in 31:12
	function word_t encode_inst(input int a);
		logic [2:0] f3;
		logic [6:0] f7;
		word_t imm;
		imm = p_imm[a];
		f7 = 7'h00;
		case (p_op[a])
			1: f3 = 3'b000;
			2: f3 = 3'b111;
			3: f3 = 3'b110;
			4: f3 = 3'b100;
			5: f3 = 3'b010;
			6: f3 = 3'b011;
			7: f3 = 3'b001;
			8: f3 = 3'b101;
			9: f3 = 3'b101;
			default: f3 = 3'b000;
		endcase
		// sub and sra
		if (p_op[a] == 1 || p_op[a] == 9)
			f7 = 7'h20;
		case (p_kind[a])
			CLS_ALU_R:
				return {f7, 5'(p_rs2[a]), 5'(p_rs1[a]), f3, 5'(p_rd[a]), OPC_OP};
			CLS_ALU_I:
			begin
				if (p_op[a] >= 7)
					return {f7, imm[4:0], 5'(p_rs1[a]), f3, 5'(p_rd[a]), OPC_OP_IMM};
				return {imm[11:0], 5'(p_rs1[a]), f3, 5'(p_rd[a]), OPC_OP_IMM};
			end
			CLS_BRANCH:
				return {imm[11:5], 5'(p_rs2[a]), 5'(p_rs1[a]), 3'(p_op[a]), imm[4:0], OPC_BRANCH};
			CLS_LOAD:
				return {imm[11:0], 5'(p_rs1[a]), 3'b010, 5'(p_rd[a]), OPC_LOAD};
			CLS_STORE:
				return {imm[11:5], 5'(p_rs2[a]), 5'(p_rs1[a]), 3'b010, imm[4:0], OPC_STORE};
			CLS_JAL:
				return {imm[19:0], 5'(p_rd[a]), OPC_JAL};
			default:
				return '0;
		endcase
	endfunction

	// --------------------------------------------------
	// program and data image
	// --------------------------------------------------
	task build_program();
		int sel;
		int k;
		word_t r;
		for (int a = 0; a < 256; a++)
		begin
			p_kind[a] = CLS_HALT;
			p_op[a] = 0;
			p_rd[a] = 0;
			p_rs1[a] = 0;
			p_rs2[a] = 0;
			p_imm[a] = '0;
		end
		for (int a = 0; a < BODY_LEN; a++)
		begin
			sel = rand_below(8);
			p_rd[a] = rand_below(32);
			p_rs1[a] = rand_below(32);
			p_rs2[a] = rand_below(32);
			// forward offset 1..4, never past the body end
			k = 1 + rand_below(4);
			if (k > BODY_LEN - a)
				k = BODY_LEN - a;
			case (sel)
				0, 1:
				begin
					p_kind[a] = CLS_ALU_R;
					p_op[a] = rand_below(10);
				end
				2, 3:
				begin
					p_kind[a] = CLS_ALU_I;
					p_op[a] = rand_below(10);
					// no subtract-immediate
					if (p_op[a] == 1)
						p_op[a] = 0;
					r = next_rand();
					if (p_op[a] >= 7)
						p_imm[a] = word_t'(rand_below(32));
					else
						p_imm[a] = {{20{r[27]}}, r[27:16]};
				end
				4:
				begin
					p_kind[a] = CLS_BRANCH;
					p_op[a] = int'(BR_F3[rand_below(6)]);
					p_imm[a] = word_t'(k);
				end
				5:
				begin
					p_kind[a] = CLS_LOAD;
					p_rs1[a] = 0;
					p_imm[a] = word_t'(rand_below(64));
				end
				6:
				begin
					p_kind[a] = CLS_STORE;
					p_rs1[a] = 0;
					p_imm[a] = word_t'(rand_below(64));
				end
				default:
				begin
					p_kind[a] = CLS_JAL;
					p_imm[a] = word_t'(k);
				end
			endcase
		end
		// epilogue dumps x1..x31 to 128+i
		for (int i = 1; i < NUM_REGS; i++)
		begin
			p_kind[BODY_LEN + i - 1] = CLS_STORE;
			p_rs2[BODY_LEN + i - 1] = i;
			p_imm[BODY_LEN + i - 1] = word_t'(EPI_BASE + i);
		end
		for (int a = 0; a < 256; a++)
		begin
			imem[a] = encode_inst(a);
			if (a < 64)
				dmem[a] = next_rand();
			else
				dmem[a] = {8'(a), ~8'(a), 8'(a), ~8'(a)};
			mmem[a] = dmem[a];
		end
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	task run_reference();
		pc_t pc;
		pc_t next;
		pc_t addr;
		word_t a_val;
		word_t b_val;
		word_t res;
		word_t sum;
		logic wr;
		logic stop;
		for (int i = 0; i < NUM_REGS; i++)
			mregs[i] = '0;
		pc = '0;
		stop = 1'b0;
		while (!stop && fetch_trace.size() < 256)
		begin
			fetch_trace.push_back(pc);
			a_val = mregs[p_rs1[pc]];
			b_val = mregs[p_rs2[pc]];
			sum = a_val + p_imm[pc];
			addr = sum[PC_W-1:0];
			next = pc + 8'd1;
			wr = 1'b0;
			res = '0;
			case (p_kind[pc])
				CLS_ALU_R:
				begin
					res = alu_ref(p_op[pc], a_val, b_val);
					wr = 1'b1;
				end
				CLS_ALU_I:
				begin
					res = alu_ref(p_op[pc], a_val, p_imm[pc]);
					wr = 1'b1;
				end
				CLS_BRANCH:
				begin
					if (branch_ref(3'(p_op[pc]), a_val, b_val))
						next = pc + p_imm[pc][PC_W-1:0];
				end
				CLS_LOAD:
				begin
					res = mmem[addr];
					wr = 1'b1;
				end
				CLS_STORE:
				begin
					mmem[addr] = b_val;
					store_addr_log.push_back(addr);
					store_data_log.push_back(b_val);
				end
				CLS_JAL:
				begin
					res = {24'b0, pc + 8'd1};
					wr = 1'b1;
					next = pc + p_imm[pc][PC_W-1:0];
				end
				default:
					stop = 1'b1;
			endcase
			// x0 stays zero
			if (wr && p_rd[pc] != 0)
				mregs[p_rd[pc]] = res;
			pc = next;
		end
	endtask

	// --------------------------------------------------
	// memory models and bus checks
	// --------------------------------------------------
	always @(posedge clk)
	begin
		if (imem_en)
		begin
			imem_data <= imem[imem_addr];
			if (fetch_idx < fetch_trace.size())
				compare_word("imem_addr", word_t'(imem_addr), word_t'(fetch_trace[fetch_idx]));
			else
			begin
				error_count++;
				$display("fetch from %h after the expected trace has ended", imem_addr);
			end
			fetch_idx++;
		end
		if (dmem_req.re)
			dmem_rdata <= dmem[dmem_req.addr];
		if (dmem_req.we)
		begin
			dmem[dmem_req.addr] = dmem_req.wdata;
			if (store_idx < store_addr_log.size())
			begin
				compare_word("dmem_req.addr", word_t'(dmem_req.addr),
					word_t'(store_addr_log[store_idx]));
				compare_word("dmem_req.wdata", dmem_req.wdata, store_data_log[store_idx]);
			end
			else
			begin
				error_count++;
				$display("store to %h has no matching entry in the expected store log",
					dmem_req.addr);
			end
			store_idx++;
		end
	end

	// run limit
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: done did not rise within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------
	initial
	begin
		build_program();
		run_reference();
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		// idle outputs before start
		@(negedge clk);
		compare_word("imem_en", word_t'(imem_en), '0);
		compare_word("dmem_req.we", word_t'(dmem_req.we), '0);
		compare_word("dmem_req.re", word_t'(dmem_req.re), '0);
		compare_word("done", word_t'(done), '0);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (done !== 1'b1)
			@(posedge clk);
		// done holds
		repeat (3)
		begin
			@(negedge clk);
			compare_word("done", word_t'(done), 32'd1);
		end
		compare_word("fetch_count", word_t'(fetch_idx), word_t'(fetch_trace.size()));
		compare_word("store_count", word_t'(store_idx), word_t'(store_addr_log.size()));
		for (int i = 1; i < NUM_REGS; i++)
			compare_word($sformatf("dmem[%0d]", EPI_BASE + i), dmem[EPI_BASE + i], mregs[i]);
		$display("errors: %0d, fetches: %0d, stores: %0d", error_count, fetch_idx, store_idx);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- flist.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_branch.sv
hw/rv_control.sv
hw/rv_core.sv
verif/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/tb_rv_core

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core \
	-f flist.f -o tb_rv_core
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0
